// File: include/ahb_debug_bridge_config.svh
`ifndef AHB_DEBUG_BRIDGE_CONFIG_SVH
`define AHB_DEBUG_BRIDGE_CONFIG_SVH

// DP and AP register byte addresses
`define DP_ADDR_SELECT  8'h08
`define AP_ADDR_CSW     8'h00
`define AP_ADDR_TAR     8'h04
`define AP_ADDR_DRW     8'h0C
`define AP_ADDR_BD0     8'h10

// ADIv5 acknowledge codes
`define STAT_OK         3'd1
`define STAT_FAULT      3'd4

// AHB-Lite encodings
`define HTRANS_IDLE     2'b00
`define HTRANS_BUSY     2'b01
`define HRESP_OKAY      1'b0
`define HRESP_ERROR     1'b1

// Field positions inside CSW and SELECT
`define CSW_WIDTH_LSB   0
`define CSW_AUTOINC_LSB 4
`define SEL_APBANK_LSB  4
`define CSW_INC_SINGLE  2'b01

// FIFO word widths
`define CMD_WIDTH       42
`define RESP_WIDTH      35

`endif

// File: hw/ahb_debug_bridge_pkg.sv
package ahb_debug_bridge_pkg;

   // AHB address, also used for the tracked TAR
   typedef logic [31:0] addr_t;

   // Data word on AHB and in DRW or BDn
   typedef logic [31:0] word_t;

   // Transfer size, same coding as the CSW width field
   typedef logic [2:0] size_t;

   // ADIv5 acknowledge
   typedef logic [2:0] stat_t;

   // DP or AP register byte address
   typedef logic [7:0] reg_addr_t;

   // Wrapping count of commands, at most four in flight
   typedef logic [2:0] cnt_t;

   // Entry of the command FIFO
   typedef struct packed {
      logic      ap_ndp;
      logic      rnw;
      reg_addr_t reg_addr;
      word_t     data;
   } adiv5_cmd_t;

   // Entry of the response FIFO
   typedef struct packed {
      stat_t stat;
      word_t data;
   } adiv5_resp_t;

   // AHB transfer taken from the address phase
   typedef struct packed {
      addr_t addr;
      size_t size;
      logic  write;
   } ahb_req_t;

   // Command sequencer states
   typedef enum logic [3:0] {
      SEQ_INIT_SELECT,
      SEQ_INIT_CSW,
      SEQ_WAIT_CSW,
      SEQ_IDLE,
      SEQ_SELECT_BANK,
      SEQ_SET_CSW,
      SEQ_SET_TAR,
      SEQ_ACCESS_DRW,
      SEQ_ACCESS_BD,
      SEQ_WAIT_RESP
   } seq_state_t;

endpackage

// File: hw/ahb_transfer_capture.sv
`include "ahb_debug_bridge_config.svh"

module ahb_transfer_capture
(
   input  logic                             CLK,
   input  logic                             arst_n,
   input  logic                             hsel,
   input  logic                             hready,
   input  logic                             hwrite,
   input  logic [1:0]                       htrans,
   input  ahb_debug_bridge_pkg::size_t      hsize,
   input  ahb_debug_bridge_pkg::addr_t      haddr,
   input  ahb_debug_bridge_pkg::word_t      hwdata,
   input  logic                             done,
   input  logic                             fault,
   input  ahb_debug_bridge_pkg::word_t      rdata,
   output ahb_debug_bridge_pkg::ahb_req_t   req,
   output logic                             req_valid,
   output ahb_debug_bridge_pkg::word_t      wdata,
   output logic                             hreadyout,
   output logic                             hresp,
   output ahb_debug_bridge_pkg::word_t      hrdata
);

   logic accept;
   logic err_wait;

   // Valid address phase, IDLE and BUSY carry no transfer
   assign accept = hsel && hready && (htrans != `HTRANS_IDLE) && (htrans != `HTRANS_BUSY);

   always_ff @(posedge CLK or negedge arst_n)
   begin
      if (!arst_n)
      begin
         req_valid <= 1'b0;
         hreadyout <= 1'b1;
         hresp     <= `HRESP_OKAY;
         err_wait  <= 1'b0;
      end
      else
      begin
         req_valid <= accept;
         // ERROR is dropped once the master has seen it with HREADYOUT high
         if (hreadyout)
            hresp <= `HRESP_OKAY;
         if (accept)
            hreadyout <= 1'b0;
         if (err_wait)
         begin
            hreadyout <= 1'b1;
            err_wait  <= 1'b0;
         end
         else if (done)
         begin
            if (fault)
            begin
               // First cycle of the two-cycle ERROR response
               hresp    <= `HRESP_ERROR;
               err_wait <= 1'b1;
            end
            else
               hreadyout <= 1'b1;
         end
      end
   end

   always_ff @(posedge CLK)
   begin
      if (accept)
      begin
         req.addr  <= haddr;
         req.size  <= hsize;
         req.write <= hwrite;
      end
      // Data phase runs while req_valid is high
      if (req_valid && req.write)
         wdata <= hwdata;
      if (done)
         hrdata <= rdata;
   end

endmodule

// File: hw/adiv5_resp_tracker.sv
`include "ahb_debug_bridge_config.svh"

module adiv5_resp_tracker
(
   input  logic                                CLK,
   input  logic                                arst_n,
   input  logic                                cmd_issued,
   input  logic                                resp_empty,
   input  ahb_debug_bridge_pkg::adiv5_resp_t   resp_data,
   output logic                                resp_rden,
   output logic                                all_recvd,
   output ahb_debug_bridge_pkg::adiv5_resp_t   last_resp,
   output ahb_debug_bridge_pkg::stat_t         stat,
   output logic                                fault,
   output logic                                fault_event
);

   import ahb_debug_bridge_pkg::*;

   cnt_t issued_cnt;
   cnt_t recvd_cnt;
   logic resp_check;

   // Drain responses as soon as they show up
   assign resp_rden = !resp_empty;

   // A command written this cycle is not yet in issued_cnt
   assign all_recvd = (issued_cnt == recvd_cnt) && !cmd_issued;

   assign fault = (stat != `STAT_OK);

   always_ff @(posedge CLK or negedge arst_n)
   begin
      if (!arst_n)
      begin
         issued_cnt  <= '0;
         recvd_cnt   <= '0;
         resp_check  <= 1'b0;
         stat        <= `STAT_OK;
         fault_event <= 1'b0;
      end
      else
      begin
         resp_check  <= resp_rden;
         fault_event <= 1'b0;
         if (cmd_issued)
            issued_cnt <= issued_cnt + cnt_t'(1);
         if (resp_check)
         begin
            recvd_cnt <= recvd_cnt + cnt_t'(1);
            if (resp_data.stat != `STAT_OK)
            begin
               fault_event <= 1'b1;
               // Keep the first failing status
               if (stat == `STAT_OK)
                  stat <= resp_data.stat;
            end
         end
      end
   end

   always_ff @(posedge CLK)
   begin
      if (resp_check)
         last_resp <= resp_data;
   end

endmodule

// File: hw/adiv5_cmd_sequencer.sv
`include "ahb_debug_bridge_config.svh"

module adiv5_cmd_sequencer
(
   input  logic                                CLK,
   input  logic                                arst_n,
   input  logic [7:0]                          apsel,
   input  ahb_debug_bridge_pkg::ahb_req_t      req,
   input  logic                                req_valid,
   input  ahb_debug_bridge_pkg::word_t         wdata,
   input  logic                                cmd_full,
   input  logic                                all_recvd,
   input  ahb_debug_bridge_pkg::adiv5_resp_t   last_resp,
   input  logic                                fault_event,
   output ahb_debug_bridge_pkg::adiv5_cmd_t    cmd_data,
   output logic                                cmd_wren,
   output logic                                cmd_issued,
   output logic                                done,
   output ahb_debug_bridge_pkg::word_t         rdata
);

   import ahb_debug_bridge_pkg::*;

   localparam size_t      SIZE_WORD = 3'd2;
   localparam logic [3:0] BANK_MEM  = 4'h0;
   localparam logic [3:0] BANK_BD   = 4'h1;

   seq_state_t state;
   seq_state_t next_st;
   seq_state_t route_st;
   logic [3:0] bank_req;
   logic [3:0] route_bank;
   logic [3:0] cur_bank;

   // Shadows of the target's registers
   word_t      sel;
   word_t      csw;
   addr_t      tar;

   word_t      sel_init;
   word_t      sel_next;
   word_t      csw_next;
   size_t      csw_width;
   logic       autoinc_single;
   logic       bd_hit;
   logic       pending;
   logic       issue_req;
   logic       issue;
   adiv5_cmd_t cmd_next;

   function automatic adiv5_cmd_t make_cmd(input logic ap, input logic rd,
                                           input reg_addr_t ra, input word_t d);
      adiv5_cmd_t c;
      c.ap_ndp   = ap;
      c.rnw      = rd;
      c.reg_addr = ra;
      c.data     = rd ? '0 : d;
      return c;
   endfunction

   assign csw_width      = csw[`CSW_WIDTH_LSB +: 3];
   assign autoinc_single = (csw[`CSW_AUTOINC_LSB +: 2] == `CSW_INC_SINGLE);
   assign cur_bank       = sel[`SEL_APBANK_LSB +: 4];
   assign sel_init       = {apsel, 24'h0};
   assign cmd_issued     = cmd_wren;

   always_comb
   begin
      sel_next = sel;
      sel_next[`SEL_APBANK_LSB +: 4] = bank_req;
      csw_next = csw;
      csw_next[`CSW_WIDTH_LSB +: 3] = req.size;
   end

   // Cheapest way to reach the requested address
   always_comb
   begin
      bd_hit = (req.size == SIZE_WORD) && (tar[3:0] == 4'h0) &&
               (req.addr[31:4] == tar[31:4]);
      if (req.size != csw_width)
      begin
         route_st   = SEQ_SET_CSW;
         route_bank = BANK_MEM;
      end
      else if (req.addr == tar)
      begin
         route_st   = SEQ_ACCESS_DRW;
         route_bank = BANK_MEM;
      end
      else if (bd_hit)
      begin
         route_st   = SEQ_ACCESS_BD;
         route_bank = BANK_BD;
      end
      else
      begin
         route_st   = SEQ_SET_TAR;
         route_bank = BANK_MEM;
      end
   end

   // Command of the current state, sent next cycle when the FIFO has room
   always_comb
   begin
      issue_req = 1'b1;
      cmd_next  = make_cmd(1'b0, 1'b0, `DP_ADDR_SELECT, sel_next);
      case (state)
         SEQ_INIT_SELECT:
            cmd_next = make_cmd(1'b0, 1'b0, `DP_ADDR_SELECT, sel_init);
         SEQ_INIT_CSW:
            cmd_next = make_cmd(1'b1, 1'b1, `AP_ADDR_CSW, '0);
         SEQ_SELECT_BANK:
            cmd_next = make_cmd(1'b0, 1'b0, `DP_ADDR_SELECT, sel_next);
         SEQ_SET_CSW:
            cmd_next = make_cmd(1'b1, 1'b0, `AP_ADDR_CSW, csw_next);
         SEQ_SET_TAR:
            cmd_next = make_cmd(1'b1, 1'b0, `AP_ADDR_TAR, req.addr);
         SEQ_ACCESS_DRW:
            cmd_next = make_cmd(1'b1, !req.write, `AP_ADDR_DRW, wdata);
         SEQ_ACCESS_BD:
            cmd_next = make_cmd(1'b1, !req.write,
                                reg_addr_t'(`AP_ADDR_BD0 + {req.addr[3:2], 2'b00}), wdata);
         default:
            issue_req = 1'b0;
      endcase
      issue = issue_req && !cmd_full;
   end

   always_ff @(posedge CLK or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state    <= SEQ_INIT_SELECT;
         next_st  <= SEQ_IDLE;
         bank_req <= BANK_MEM;
         sel      <= '0;
         csw      <= '0;
         tar      <= '1;
         pending  <= 1'b0;
         cmd_wren <= 1'b0;
         done     <= 1'b0;
      end
      else
      begin
         cmd_wren <= issue;
         done     <= 1'b0;
         // Transfer that arrives during init waits here
         if (req_valid)
            pending <= 1'b1;
         case (state)
            SEQ_INIT_SELECT:
               if (issue)
               begin
                  sel   <= sel_init;
                  state <= SEQ_INIT_CSW;
               end
            SEQ_INIT_CSW:
               if (issue)
                  state <= SEQ_WAIT_CSW;
            SEQ_WAIT_CSW:
               if (all_recvd)
               begin
                  csw   <= last_resp.data;
                  state <= SEQ_IDLE;
               end
            SEQ_IDLE:
               if (req_valid || pending)
               begin
                  pending  <= 1'b0;
                  next_st  <= route_st;
                  bank_req <= route_bank;
                  state    <= (cur_bank != route_bank) ? SEQ_SELECT_BANK : route_st;
               end
            SEQ_SELECT_BANK:
               if (issue)
               begin
                  sel   <= sel_next;
                  state <= next_st;
               end
            SEQ_SET_CSW:
               if (issue)
               begin
                  csw   <= csw_next;
                  state <= (req.addr == tar) ? SEQ_ACCESS_DRW : SEQ_SET_TAR;
               end
            SEQ_SET_TAR:
               if (issue)
               begin
                  tar   <= req.addr;
                  state <= SEQ_ACCESS_DRW;
               end
            SEQ_ACCESS_DRW:
               if (issue)
               begin
                  if (autoinc_single)
                     tar <= tar + (addr_t'(1) << req.size);
                  state <= SEQ_WAIT_RESP;
               end
            SEQ_ACCESS_BD:
               if (issue)
                  state <= SEQ_WAIT_RESP;
            SEQ_WAIT_RESP:
               if (all_recvd)
               begin
                  done  <= 1'b1;
                  state <= SEQ_IDLE;
               end
            default:
               state <= SEQ_INIT_SELECT;
         endcase
         // A failed access leaves the target TAR unknown
         if (fault_event)
            tar <= '1;
      end
   end

   always_ff @(posedge CLK)
   begin
      if (issue)
         cmd_data <= cmd_next;
      if ((state == SEQ_WAIT_RESP) && all_recvd)
         rdata <= last_resp.data;
   end

endmodule

// File: hw/ahb_debug_bridge.sv
`include "ahb_debug_bridge_config.svh"

module ahb_debug_bridge
(
   input  logic                                CLK,
   input  logic                                arst_n,
   input  logic                                hsel,
   input  logic                                hready,
   input  logic                                hwrite,
   input  logic [1:0]                          htrans,
   input  ahb_debug_bridge_pkg::size_t         hsize,
   input  ahb_debug_bridge_pkg::addr_t         haddr,
   input  ahb_debug_bridge_pkg::word_t         hwdata,
   output logic                                hreadyout,
   output logic                                hresp,
   output ahb_debug_bridge_pkg::word_t         hrdata,
   input  logic [7:0]                          apsel,
   output ahb_debug_bridge_pkg::stat_t         stat,
   output ahb_debug_bridge_pkg::adiv5_cmd_t    cmd_data,
   output logic                                cmd_wren,
   input  logic                                cmd_full,
   input  ahb_debug_bridge_pkg::adiv5_resp_t   resp_data,
   output logic                                resp_rden,
   input  logic                                resp_empty
);

   import ahb_debug_bridge_pkg::*;

   ahb_req_t    req;
   logic        req_valid;
   word_t       wdata;
   logic        done;
   word_t       rdata;
   logic        fault;
   logic        fault_event;
   logic        cmd_issued;
   logic        all_recvd;
   adiv5_resp_t last_resp;

   // FIFO words must match the struct layouts
   if (($bits(adiv5_cmd_t) != `CMD_WIDTH) || ($bits(adiv5_resp_t) != `RESP_WIDTH))
   begin : g_width_check
      $error("FIFO word width differs from struct layout");
   end

   ahb_transfer_capture i_capture
   (
      .CLK       (CLK),
      .arst_n    (arst_n),
      .hsel      (hsel),
      .hready    (hready),
      .hwrite    (hwrite),
      .htrans    (htrans),
      .hsize     (hsize),
      .haddr     (haddr),
      .hwdata    (hwdata),
      .done      (done),
      .fault     (fault),
      .rdata     (rdata),
      .req       (req),
      .req_valid (req_valid),
      .wdata     (wdata),
      .hreadyout (hreadyout),
      .hresp     (hresp),
      .hrdata    (hrdata)
   );

   adiv5_resp_tracker i_tracker
   (
      .CLK         (CLK),
      .arst_n      (arst_n),
      .cmd_issued  (cmd_issued),
      .resp_empty  (resp_empty),
      .resp_data   (resp_data),
      .resp_rden   (resp_rden),
      .all_recvd   (all_recvd),
      .last_resp   (last_resp),
      .stat        (stat),
      .fault       (fault),
      .fault_event (fault_event)
   );

   adiv5_cmd_sequencer i_sequencer
   (
      .CLK         (CLK),
      .arst_n      (arst_n),
      .apsel       (apsel),
      .req         (req),
      .req_valid   (req_valid),
      .wdata       (wdata),
      .cmd_full    (cmd_full),
      .all_recvd   (all_recvd),
      .last_resp   (last_resp),
      .fault_event (fault_event),
      .cmd_data    (cmd_data),
      .cmd_wren    (cmd_wren),
      .cmd_issued  (cmd_issued),
      .done        (done),
      .rdata       (rdata)
   );

endmodule

// File: test/ahb_debug_bridge_props.sv
`include "ahb_debug_bridge_config.svh"

module ahb_debug_bridge_props
(
   input logic CLK,
   input logic arst_n,
   input logic cmd_wren,
   input logic cmd_full,
   input logic resp_rden,
   input logic resp_empty,
   input logic hreadyout,
   input logic hresp
);

   timeunit 1ns;
   timeprecision 100ps;

   // Sequencer decides one cycle early, so a full FIFO blocks the next write
   a_no_wren_after_full: assert property (@(posedge CLK) disable iff (!arst_n)
      $past(cmd_full) |-> !cmd_wren)
      else $error("Command written in the cycle after cmd_full was high");

   a_no_read_when_empty: assert property (@(posedge CLK) disable iff (!arst_n)
      resp_empty |-> !resp_rden)
      else $error("Response FIFO read while empty");

   // Two-cycle AHB ERROR response
   a_error_two_cycle: assert property (@(posedge CLK) disable iff (!arst_n)
      (hresp == `HRESP_ERROR && !hreadyout) |=> (hresp == `HRESP_ERROR && hreadyout))
      else $error("ERROR response not followed by ERROR with hreadyout high");

endmodule

bind ahb_debug_bridge ahb_debug_bridge_props i_props
(
   .CLK        (CLK),
   .arst_n     (arst_n),
   .cmd_wren   (cmd_wren),
   .cmd_full   (cmd_full),
   .resp_rden  (resp_rden),
   .resp_empty (resp_empty),
   .hreadyout  (hreadyout),
   .hresp      (hresp)
);

// File: test/tb_ahb_debug_bridge.sv
`include "ahb_debug_bridge_config.svh"

module tb_ahb_debug_bridge;

   timeunit 1ns;
   timeprecision 100ps;

   import ahb_debug_bridge_pkg::*;

   localparam string      TESTS_FILE      = "test/ahb_debug_bridge_tests.txt";
   localparam int         CYCLES_PER_TEST = 80;
   localparam int         CYCLE_MARGIN    = 200;
   localparam logic [7:0] APSEL           = 8'h02;

   logic        CLK = 1'b0;
   logic        arst_n;
   logic        hsel;
   logic        hready;
   logic        hwrite;
   logic [1:0]  htrans;
   size_t       hsize;
   addr_t       haddr;
   word_t       hwdata;
   logic        hreadyout;
   logic        hresp;
   word_t       hrdata;
   stat_t       stat;
   adiv5_cmd_t  cmd_data;
   logic        cmd_wren;
   logic        cmd_full;
   adiv5_resp_t resp_data;
   logic        resp_rden;
   logic        resp_empty;

   // Test table
   string       t_name[$];
   logic        t_write[$];
   size_t       t_size[$];
   addr_t       t_addr[$];
   word_t       t_wdata[$];
   logic        t_fault[$];
   word_t       t_exp[$];
   logic        t_eresp[$];
   int          t_ncmd[$];

   // Target model state
   word_t       m_sel;
   word_t       m_csw;
   addr_t       m_tar;
   word_t       mem [addr_t];
   adiv5_resp_t rq[$];
   int          rt[$];
   adiv5_cmd_t  first_cmd [2];
   int          total_cmds = 0;
   int          cmd_cnt = 0;
   logic        fault_flag = 1'b0;
   logic [31:0] rnd = 32'h3d79_6bed;

   int          cycles = 0;
   int          limit = 0;
   int          errors = 0;
   int          passed = 0;
   int          failed = 0;

   ahb_debug_bridge i_ahb_debug_bridge
   (
      .CLK        (CLK),
      .arst_n     (arst_n),
      .hsel       (hsel),
      .hready     (hready),
      .hwrite     (hwrite),
      .htrans     (htrans),
      .hsize      (hsize),
      .haddr      (haddr),
      .hwdata     (hwdata),
      .hreadyout  (hreadyout),
      .hresp      (hresp),
      .hrdata     (hrdata),
      .apsel      (APSEL),
      .stat       (stat),
      .cmd_data   (cmd_data),
      .cmd_wren   (cmd_wren),
      .cmd_full   (cmd_full),
      .resp_data  (resp_data),
      .resp_rden  (resp_rden),
      .resp_empty (resp_empty)
   );

   always #10 CLK = ~CLK;

   always @(posedge CLK)
   begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles >= limit)
      begin
         $display("Timeout after %0d cycles, a transfer never completed", cycles);
         $display("Test FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Byte lanes of a transfer
   function automatic word_t lane_mask(input size_t sz, input addr_t a);
      word_t m;
      case (sz)
         3'd0:    m = 32'h0000_00ff << {a[1:0], 3'b000};
         3'd1:    m = 32'h0000_ffff << {a[1], 4'b0000};
         default: m = '1;
      endcase
      return m;
   endfunction

   // Unwritten memory returns a pattern of its own address
   function automatic word_t mem_read(input addr_t a);
      addr_t wa;
      wa = {a[31:2], 2'b00};
      if (mem.exists(wa))
         return mem[wa];
      return ~{wa[15:0], wa[31:16]};
   endfunction

   task automatic mem_access(input addr_t a, input size_t sz, input logic rd,
                             input word_t d, output word_t q);
      word_t m;
      m = lane_mask(sz, a);
      q = '0;
      if (rd)
         q = mem_read(a);
      else
         mem[{a[31:2], 2'b00}] = (mem_read(a) & ~m) | (d & m);
   endtask

   task automatic check_equal(input string tname, input string what,
                              input word_t exp, input word_t act);
      assert (exp === act)
      else
      begin
         $display("ERROR %0s %0s expected %h actual %h", tname, what, exp, act);
         errors++;
      end
   endtask

   task automatic check_bank(input logic [3:0] bank, input logic [3:0] need);
      assert (bank == need)
      else
      begin
         $display("Target got an AP access in bank %0d, register needs bank %0d", bank, need);
         errors++;
      end
   endtask

   // ADIv5 target model handling one command per call
   task automatic accept_cmd(input adiv5_cmd_t c);
      adiv5_resp_t r;
      word_t       q;
      logic [3:0]  bank;
      r.stat = `STAT_OK;
      r.data = '0;
      q      = '0;
      bank   = m_sel[`SEL_APBANK_LSB +: 4];
      if (total_cmds < 2)
         first_cmd[total_cmds] = c;
      total_cmds++;
      cmd_cnt++;
      if (!c.ap_ndp)
      begin
         if (!c.rnw && c.reg_addr == `DP_ADDR_SELECT)
            m_sel = c.data;
      end
      else if (c.reg_addr >= `AP_ADDR_BD0 && c.reg_addr < `AP_ADDR_BD0 + 8'h10)
      begin
         check_bank(bank, 4'h1);
         if (fault_flag)
            r.stat = `STAT_FAULT;
         else
            mem_access({m_tar[31:4], c.reg_addr[3:2], 2'b00}, 3'd2, c.rnw, c.data, q);
      end
      else
      begin
         check_bank(bank, 4'h0);
         case (c.reg_addr)
            `AP_ADDR_CSW:
               if (c.rnw)
                  q = m_csw;
               else
                  m_csw = c.data;
            `AP_ADDR_TAR:
               if (c.rnw)
                  q = m_tar;
               else
                  m_tar = c.data;
            `AP_ADDR_DRW:
               if (fault_flag)
                  r.stat = `STAT_FAULT;
               else
               begin
                  mem_access(m_tar, m_csw[`CSW_WIDTH_LSB +: 3], c.rnw, c.data, q);
                  if (m_csw[`CSW_AUTOINC_LSB +: 2] == `CSW_INC_SINGLE)
                     m_tar = m_tar + (addr_t'(1) << m_csw[`CSW_WIDTH_LSB +: 3]);
               end
            default:
            begin
               $display("Target got a command for unknown AP register %h", c.reg_addr);
               errors++;
            end
         endcase
      end
      r.data = q;
      rq.push_back(r);
      rt.push_back(cycles + 3);
   endtask

   // Command and response FIFOs on the target side
   always @(negedge CLK)
   begin
      if (arst_n)
      begin
         if (cmd_wren)
            accept_cmd(cmd_data);
         if (resp_rden)
         begin
            resp_data = rq.pop_front();
            void'(rt.pop_front());
         end
         resp_empty = !(rq.size() > 0 && rt[0] <= cycles);
         rnd = lcg_next(rnd);
         cmd_full = (rnd[31:29] == 3'd0);
      end
   end

   task automatic load_tests(output logic ok);
      int          fd;
      int          n;
      string       line;
      logic [255:0] nm;
      logic [31:0] w, sz, ad, wd, f, ex, er, nc;
      ok = 1'b0;
      fd = $fopen(TESTS_FILE, "r");
      if (fd != 0)
      begin
         while (!$feof(fd))
         begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#")
            begin
               n = $sscanf(line, "%s %h %h %h %h %h %h %h %h",
                           nm, w, sz, ad, wd, f, ex, er, nc);
               if (n == 9)
               begin
                  t_name.push_back($sformatf("%0s", nm));
                  t_write.push_back(w[0]);
                  t_size.push_back(sz[2:0]);
                  t_addr.push_back(ad);
                  t_wdata.push_back(wd);
                  t_fault.push_back(f[0]);
                  t_exp.push_back(ex);
                  t_eresp.push_back(er[0]);
                  t_ncmd.push_back(int'(nc));
               end
            end
         end
         $fclose(fd);
         ok = (t_name.size() > 0);
      end
   endtask

   task automatic report(input string tname, input int err_before);
      if (errors == err_before)
      begin
         passed++;
         $display("PASS %0s", tname);
      end
      else
      begin
         failed++;
         $display("FAIL %0s", tname);
      end
   endtask

   task automatic run_transfer(input int i);
      int   err_before;
      logic last_hresp;
      word_t m;
      err_before = errors;
      @(negedge CLK);
      fault_flag = t_fault[i];
      cmd_cnt    = 0;
      htrans     = 2'b10;
      hwrite     = t_write[i];
      hsize      = t_size[i];
      haddr      = t_addr[i];
      @(negedge CLK);
      htrans     = `HTRANS_IDLE;
      hwdata     = t_wdata[i];
      last_hresp = hresp;
      while (!hreadyout)
      begin
         last_hresp = hresp;
         @(negedge CLK);
      end
      if (t_eresp[i])
      begin
         check_equal(t_name[i], "hresp before ready", 32'(`HRESP_ERROR), 32'(last_hresp));
         check_equal(t_name[i], "hresp", 32'(`HRESP_ERROR), 32'(hresp));
         check_equal(t_name[i], "stat", 32'(`STAT_FAULT), 32'(stat));
      end
      else
      begin
         check_equal(t_name[i], "hresp", 32'(`HRESP_OKAY), 32'(hresp));
         check_equal(t_name[i], "stat", 32'(`STAT_OK), 32'(stat));
         if (!t_write[i])
         begin
            m = lane_mask(t_size[i], t_addr[i]);
            check_equal(t_name[i], "hrdata", t_exp[i] & m, hrdata & m);
         end
      end
      check_equal(t_name[i], "command count", 32'(t_ncmd[i]), 32'(cmd_cnt));
      report(t_name[i], err_before);
   endtask

   task automatic run_tests();
      int err_before;
      limit = CYCLES_PER_TEST * t_name.size() + CYCLE_MARGIN;
      repeat (4) @(negedge CLK);
      arst_n = 1'b1;
      // Init is over once both commands are answered
      while (!(total_cmds >= 2 && rq.size() == 0 && resp_empty))
         @(negedge CLK);
      repeat (4) @(negedge CLK);
      err_before = errors;
      check_equal("init", "select header", word_t'({1'b0, 1'b0, `DP_ADDR_SELECT}),
                  word_t'({first_cmd[0].ap_ndp, first_cmd[0].rnw, first_cmd[0].reg_addr}));
      check_equal("init", "select data", {APSEL, 24'h0}, first_cmd[0].data);
      check_equal("init", "csw read header", word_t'({1'b1, 1'b1, `AP_ADDR_CSW}),
                  word_t'({first_cmd[1].ap_ndp, first_cmd[1].rnw, first_cmd[1].reg_addr}));
      report("init", err_before);
      for (int i = 0; i < t_name.size(); i++)
         run_transfer(i);
      $display("Tests passed: %0d, failed: %0d", passed, failed);
      if (failed == 0 && errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   endtask

   initial
   begin
      logic ok;
      arst_n     = 1'b0;
      hsel       = 1'b1;
      hready     = 1'b1;
      hwrite     = 1'b0;
      htrans     = `HTRANS_IDLE;
      hsize      = 3'd2;
      haddr      = '0;
      hwdata     = '0;
      cmd_full   = 1'b0;
      resp_data  = '0;
      resp_empty = 1'b1;
      m_sel      = '0;
      // Word width with single auto-increment
      m_csw      = 32'h0000_0012;
      m_tar      = '0;
      load_tests(ok);
      if (!ok)
      begin
         $display("Could not read any test from %0s", TESTS_FILE);
         $display("Test FAILED");
         $finish;
      end
      else
         run_tests();
   end

endmodule

// File: test/ahb_debug_bridge_tests.txt
# name write size addr wdata fault exp_data exp_resp exp_cmds (hex fields)
# exp_resp 0 is OKAY, 1 is ERROR
wr_word        1 2 00001000 deadbeef 0 00000000 0 2
rd_word        0 2 00001000 00000000 0 deadbeef 0 2
wr_seq         1 2 00001004 12345678 0 00000000 0 1
rd_seq         0 2 00001004 00000000 0 12345678 0 2
wr_byte        1 0 00001011 0000ab00 0 00000000 0 3
rd_byte        0 0 00001011 00000000 0 0000ab00 0 2
rd_word_resize 0 2 00001000 00000000 0 deadbeef 0 3
wr_pre_bd      1 2 00001ffc 11112222 0 00000000 0 2
wr_bd2         1 2 00002008 cafe0008 0 00000000 0 2
rd_bd2         0 2 00002008 00000000 0 cafe0008 0 1
rd_bank0       0 2 00001ffc 00000000 0 11112222 0 3
wr_half        1 1 00002002 beef0000 0 00000000 0 3
rd_half        0 1 00002002 00000000 0 beef0000 0 2
wr_fault       1 2 00003000 55aa55aa 1 00000000 1 3
rd_after_fault 0 2 00001000 00000000 0 00000000 1 2

// File: ahb_debug_bridge.f
+incdir+include
hw/ahb_debug_bridge_pkg.sv
hw/ahb_transfer_capture.sv
hw/adiv5_resp_tracker.sv
hw/adiv5_cmd_sequencer.sv
hw/ahb_debug_bridge.sv
test/ahb_debug_bridge_props.sv
test/tb_ahb_debug_bridge.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ahb_debug_bridge
FLIST     ?= ahb_debug_bridge.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
